// ==== source/vertex_cfg.svh ====
`ifndef VERTEX_CFG_SVH
`define VERTEX_CFG_SVH

// width of one element of the in-degree, out-degree and edge index arrays
`define VERTEX_BITS 32

// elements carried by one cacheline
`define VERTICES_PER_LINE 4

// byte address width of the read port
`define ADDR_BITS 32

// vertex counts and vertex ids
`define COUNT_BITS 16

// entries in the output vertex FIFO
`define QUEUE_DEPTH 8

`endif

// ==== source/vertex_pkg.sv ====
`default_nettype none

`include "vertex_cfg.svh"

package vertex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [`VERTEX_BITS-1:0] vertex_word_t;
	typedef logic [`VERTICES_PER_LINE*`VERTEX_BITS-1:0] cacheline_t; // element 0 in the low bits
	typedef logic [`ADDR_BITS-1:0] addr_t;
	typedef logic [`COUNT_BITS-1:0] count_t;
	typedef logic [$clog2(`VERTICES_PER_LINE+1)-1:0] line_count_t; // 0 .. VERTICES_PER_LINE

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		in_degree,
		out_degree,
		edges_idx
	} vertex_array_t;

	typedef enum logic [1:0] {
		idle,
		check,
		issue,
		wait_batch
	} req_state_t;

	////////////////////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		count_t num_vertices;
		addr_t  in_degree_base;  // 16 byte aligned
		addr_t  out_degree_base;
		addr_t  edges_idx_base;
	} job_t;

	typedef struct packed {
		addr_t         address;
		vertex_array_t array;
		line_count_t   count; // real vertices in this batch
	} read_req_t;

	typedef struct packed {
		vertex_array_t array;
		line_count_t   count; // echoed from the request
		cacheline_t    data;
	} read_resp_t;

	typedef struct packed {
		count_t       id;
		vertex_word_t in_degree;
		vertex_word_t out_degree;
		vertex_word_t edges_idx;
	} vertex_t;

endpackage

`default_nettype wire

// ==== source/vertex_request_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vertex_cfg.svh"

module vertex_request_gen import vertex_pkg::*; (
	input  wire            clock,
	input  wire            rstn,
	input  wire job_t      job,
	input  wire            job_valid,
	output logic           job_ready,
	input  wire            room,
	input  wire            batch_done,
	output read_req_t      read_req,
	output logic           read_req_valid,
	input  wire            read_req_ready,
	output logic           job_start
);

	localparam int line_bytes = `VERTICES_PER_LINE * `VERTEX_BITS / 8;

	req_state_t    state, next_state;
	job_t          job_r;
	count_t        remaining;   // vertices not yet covered by a finished batch
	addr_t         offset;      // byte offset of the current batch
	vertex_array_t array_sel;
	line_count_t   batch_count;
	addr_t         base;
	logic          req_done;    // request handshake

	assign job_ready = (state == idle);
	assign job_start = job_valid && job_ready;
	assign read_req_valid = (state == issue);
	assign req_done = read_req_valid && read_req_ready;

	// last batch may be short
	assign batch_count = (remaining >= count_t'(`VERTICES_PER_LINE)) ?
		line_count_t'(`VERTICES_PER_LINE) : line_count_t'(remaining);

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (job_valid) begin
					// skip check when the queue already has space
					if (job.num_vertices != '0 && room)
						next_state = issue;
					else
						next_state = check;
				end
			end
			check: begin
				if (remaining == '0)
					next_state = idle; // empty job
				else if (room)
					next_state = issue;
			end
			issue: begin
				if (req_done && array_sel == edges_idx)
					next_state = wait_batch;
			end
			wait_batch: begin
				if (batch_done)
					next_state = (remaining == count_t'(batch_count)) ? idle : check;
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state     <= idle;
			remaining <= '0;
			offset    <= '0;
			array_sel <= in_degree;
		end else begin
			state <= next_state;
			if (job_start) begin
				remaining <= job.num_vertices;
				offset    <= '0;
				array_sel <= in_degree;
			end
			if (req_done) begin
				case (array_sel)
					in_degree:  array_sel <= out_degree;
					out_degree: array_sel <= edges_idx;
					default:    array_sel <= in_degree; // wraps for the next batch
				endcase
			end
			if (state == wait_batch && batch_done) begin
				remaining <= remaining - count_t'(batch_count);
				offset    <= offset + addr_t'(line_bytes);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (job_start)
			job_r <= job;
	end

	////////////////////////////////////////////////////////////////////////////
	// request forming
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (array_sel)
			in_degree:  base = job_r.in_degree_base;
			out_degree: base = job_r.out_degree_base;
			default:    base = job_r.edges_idx_base;
		endcase
		read_req.address = base + offset;
		read_req.array   = array_sel;
		read_req.count   = batch_count;
	end

endmodule

`default_nettype wire

// ==== source/cacheline_gather.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheline_gather import vertex_pkg::*; (
	input  wire              clock,
	input  wire              rstn,
	input  wire read_resp_t  read_resp,
	input  wire              read_resp_valid,
	input  wire              batch_done,
	output cacheline_t       in_degree_line,
	output cacheline_t       out_degree_line,
	output cacheline_t       edges_idx_line,
	output line_count_t      count,
	output logic             lines_valid
);

	logic [2:0] arrived; // one flag per array, indexed by vertex_array_t

	// all three lines of the batch are in
	assign lines_valid = &arrived;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			arrived <= '0;
		end else begin
			if (batch_done)
				arrived <= '0; // next batch not requested yet, no overlap
			else if (read_resp_valid)
				arrived[read_resp.array] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// line registers, responses come back in any order
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (read_resp_valid) begin
			case (read_resp.array)
				in_degree:  in_degree_line  <= read_resp.data;
				out_degree: out_degree_line <= read_resp.data;
				default:    edges_idx_line  <= read_resp.data;
			endcase
			count <= read_resp.count; // same on all three
		end
	end

endmodule

`default_nettype wire

// ==== source/vertex_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vertex_cfg.svh"

module vertex_unpack import vertex_pkg::*; (
	input  wire              clock,
	input  wire              rstn,
	input  wire              job_start,
	input  wire              lines_valid,
	input  wire cacheline_t  in_degree_line,
	input  wire cacheline_t  out_degree_line,
	input  wire cacheline_t  edges_idx_line,
	input  wire line_count_t count,
	output logic             batch_done,
	output logic             push,
	output vertex_t          vertex
);

	logic         running;  // one candidate per cycle while set
	line_count_t  shift;    // element within the batch
	count_t       next_id;  // id within the job
	vertex_word_t in_word;
	vertex_word_t out_word;
	vertex_word_t edges_word;

	// element k of each line
	assign in_word    = in_degree_line[shift*`VERTEX_BITS +: `VERTEX_BITS];
	assign out_word   = out_degree_line[shift*`VERTEX_BITS +: `VERTEX_BITS];
	assign edges_word = edges_idx_line[shift*`VERTEX_BITS +: `VERTEX_BITS];

	////////////////////////////////////////////////////////////////////////////
	// batch walk
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			running    <= 1'b0;
			shift      <= '0;
			next_id    <= '0;
			push       <= 1'b0;
			batch_done <= 1'b0;
		end else begin
			// isolated vertices never reach the queue
			push       <= running && (in_word != '0 || out_word != '0);
			batch_done <= 1'b0;
			if (job_start)
				next_id <= '0;
			if (running) begin
				next_id <= next_id + 1'b1; // dropped ones count too
				shift   <= shift + 1'b1;
				if (shift + 1'b1 == count) begin
					running    <= 1'b0;
					batch_done <= 1'b1;
				end
			end else if (lines_valid && !batch_done) begin
				// lines stay valid during the done pulse
				running <= 1'b1;
				shift   <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (running) begin
			vertex.id         <= next_id;
			vertex.in_degree  <= in_word;
			vertex.out_degree <= out_word;
			vertex.edges_idx  <= edges_word;
		end
	end

endmodule

`default_nettype wire

// ==== source/vertex_job_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vertex_cfg.svh"

module vertex_job_queue import vertex_pkg::*; (
	input  wire          clock,
	input  wire          rstn,
	input  wire          push,
	input  wire vertex_t vertex_in,
	output logic         room,
	output vertex_t      vertex,
	output logic         vertex_valid,
	input  wire          vertex_ready
);

	localparam int ptr_bits = $clog2(`QUEUE_DEPTH);
	localparam int used_bits = $clog2(`QUEUE_DEPTH + 1);

	vertex_t              mem [`QUEUE_DEPTH];
	logic [ptr_bits-1:0]  wr_ptr;
	logic [ptr_bits-1:0]  rd_ptr;
	logic [used_bits-1:0] used;    // occupancy
	logic                 do_push;
	logic                 do_pop;

	assign vertex_valid = (used != '0);
	assign vertex = mem[rd_ptr]; // head visible the cycle after the write
	assign do_pop = vertex_valid && vertex_ready;
	assign do_push = push && (used != used_bits'(`QUEUE_DEPTH));

	// space for one more full batch
	assign room = (`QUEUE_DEPTH - int'(used)) >= `VERTICES_PER_LINE;

	////////////////////////////////////////////////////////////////////////////
	// pointers and count
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_bits'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_bits'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				used <= used + 1'b1;
			else if (do_pop && !do_push)
				used <= used - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= vertex_in;
	end

endmodule

`default_nettype wire

// ==== source/vertex_job_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module vertex_job_control import vertex_pkg::*; (
	input  wire             clock,
	input  wire             rstn,
	input  wire job_t       job,
	input  wire             job_valid,
	output logic            job_ready,
	output read_req_t       read_req,
	output logic            read_req_valid,
	input  wire             read_req_ready,
	input  wire read_resp_t read_resp,
	input  wire             read_resp_valid,
	output vertex_t         vertex,
	output logic            vertex_valid,
	input  wire             vertex_ready
);

	logic        job_start;
	logic        room;
	logic        batch_done;
	logic        lines_valid;
	cacheline_t  in_degree_line;
	cacheline_t  out_degree_line;
	cacheline_t  edges_idx_line;
	line_count_t line_count;
	logic        push;
	vertex_t     unpacked_vertex;

	////////////////////////////////////////////////////////////////////////////
	// requests, gather, unpack, queue
	////////////////////////////////////////////////////////////////////////////
	vertex_request_gen request_gen (
		.clock          (clock),
		.rstn           (rstn),
		.job            (job),
		.job_valid      (job_valid),
		.job_ready      (job_ready),
		.room           (room),
		.batch_done     (batch_done),
		.read_req       (read_req),
		.read_req_valid (read_req_valid),
		.read_req_ready (read_req_ready),
		.job_start      (job_start)
	);

	cacheline_gather gather (
		.clock           (clock),
		.rstn            (rstn),
		.read_resp       (read_resp),
		.read_resp_valid (read_resp_valid),
		.batch_done      (batch_done),
		.in_degree_line  (in_degree_line),
		.out_degree_line (out_degree_line),
		.edges_idx_line  (edges_idx_line),
		.count           (line_count),
		.lines_valid     (lines_valid)
	);

	vertex_unpack unpack (
		.clock           (clock),
		.rstn            (rstn),
		.job_start       (job_start),
		.lines_valid     (lines_valid),
		.in_degree_line  (in_degree_line),
		.out_degree_line (out_degree_line),
		.edges_idx_line  (edges_idx_line),
		.count           (line_count),
		.batch_done      (batch_done),
		.push            (push),
		.vertex          (unpacked_vertex)
	);

	vertex_job_queue queue (
		.clock        (clock),
		.rstn         (rstn),
		.push         (push),
		.vertex_in    (unpacked_vertex),
		.room         (room),
		.vertex       (vertex),
		.vertex_valid (vertex_valid),
		.vertex_ready (vertex_ready)
	);

endmodule

`default_nettype wire

// ==== testbench/vertex_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vertex_cfg.svh"

module vertex_checker import vertex_pkg::*; (
	input  wire            clock,
	input  wire            rstn,
	input  wire job_t      job,
	input  wire            job_valid,
	input  wire            job_ready,
	input  wire read_req_t read_req,
	input  wire            read_req_valid,
	input  wire            read_req_ready,
	input  wire vertex_t   vertex,
	input  wire            vertex_valid,
	input  wire            vertex_ready,
	output int             error_count,
	output int             pending,
	output int             vertices_checked,
	output int             requests_checked
);

	localparam int line_bytes = `VERTICES_PER_LINE * `VERTEX_BITS / 8;

	read_req_t exp_req_q [$];
	vertex_t   exp_vertex_q [$];

	task automatic compare_field(input string name, input logic [31:0] want,
		input logic [31:0] got);
		if (want !== got) begin
			$display("** Error: %s expected %h, got %h", name, want, got);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// expectations from one accepted job
	////////////////////////////////////////////////////////////////////////////
	task automatic expect_job(input job_t j);
		int          left;
		int          n;
		logic [31:0] off;
		read_req_t   r;
		vertex_t     v;
		left = j.num_vertices;
		off = 0;
		while (left > 0) begin
			n = (left >= `VERTICES_PER_LINE) ? `VERTICES_PER_LINE : left;
			r.count = line_count_t'(n);
			r.array = in_degree;
			r.address = j.in_degree_base + off;
			exp_req_q.push_back(r);
			r.array = out_degree;
			r.address = j.out_degree_base + off;
			exp_req_q.push_back(r);
			r.array = edges_idx;
			r.address = j.edges_idx_base + off;
			exp_req_q.push_back(r);
			left -= n;
			off += line_bytes;
		end
		for (int i = 0; i < int'(j.num_vertices); i++) begin
			v.id = count_t'(i);
			v.in_degree = vertex_word_t'(((j.in_degree_base >> 2) + i) % 7);
			v.out_degree = vertex_word_t'(((j.out_degree_base >> 2) + i) % 5);
			v.edges_idx = vertex_word_t'((j.edges_idx_base >> 2) + i);
			if (v.in_degree != 0 || v.out_degree != 0) // isolated ones are dropped
				exp_vertex_q.push_back(v);
		end
	endtask

	task automatic check_request(input read_req_t got);
		read_req_t want;
		requests_checked++;
		if (exp_req_q.size() == 0) begin
			$display("unexpected read request to address %h", got.address);
			error_count++;
			return;
		end
		want = exp_req_q.pop_front();
		compare_field("read_req.address", want.address, got.address);
		compare_field("read_req.array", 32'(want.array), 32'(got.array));
		compare_field("read_req.count", 32'(want.count), 32'(got.count));
	endtask

	task automatic check_vertex(input vertex_t got);
		vertex_t want;
		vertices_checked++;
		if (exp_vertex_q.size() == 0) begin
			$display("unexpected vertex with id %0d at the output", got.id);
			error_count++;
			return;
		end
		want = exp_vertex_q.pop_front();
		compare_field("vertex.id", 32'(want.id), 32'(got.id));
		compare_field("vertex.in_degree", want.in_degree, got.in_degree);
		compare_field("vertex.out_degree", want.out_degree, got.out_degree);
		compare_field("vertex.edges_idx", want.edges_idx, got.edges_idx);
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			// a new job may only be taken once every request of the last one went out
			if (job_ready && exp_req_q.size() != 0) begin
				$display("job_ready is high while %0d read requests are still owed",
					exp_req_q.size());
				error_count++;
			end
			if (job_valid && job_ready)
				expect_job(job);
			if (read_req_valid && read_req_ready)
				check_request(read_req);
			if (vertex_valid && vertex_ready)
				check_vertex(vertex);
		end
		pending <= exp_req_q.size() + exp_vertex_q.size(); // work still owed by the DUT
	end

endmodule

`default_nettype wire

// ==== testbench/tb_vertex_job_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vertex_cfg.svh"

module tb_vertex_job_control import vertex_pkg::*; ();

	typedef struct packed {
		count_t num_vertices;
		addr_t  in_base;
		addr_t  out_base;
		addr_t  edges_base;
		int     ready_pct;  // vertex_ready probability in percent
		int     max_delay;  // response delay in cycles
		count_t kept;       // vertices left after filtering
	} test_row_t;

	localparam int num_tests = 7;

	logic       clock = 1'b0;
	logic       rstn = 1'b0;
	job_t       job = '0;
	logic       job_valid = 1'b0;
	logic       job_ready;
	read_req_t  read_req;
	logic       read_req_valid;
	logic       read_req_ready = 1'b0;
	read_resp_t read_resp = '0;
	logic       read_resp_valid = 1'b0;
	vertex_t    vertex;
	logic       vertex_valid;
	logic       vertex_ready = 1'b0;

	test_row_t  tests [num_tests];
	int         ready_pct = 100;
	int         max_delay = 0;
	int         tb_errors = 0;
	logic       timed_out = 1'b0;
	int         check_errors;
	int         pending;
	int         vertices_checked;
	int         requests_checked;
	read_req_t  accepted_q [$];  // requests of the current batch
	read_resp_t resp_q [$];
	int         delay = 0;
	int         pick;

	vertex_job_control uut (
		.clock           (clock),
		.rstn            (rstn),
		.job             (job),
		.job_valid       (job_valid),
		.job_ready       (job_ready),
		.read_req        (read_req),
		.read_req_valid  (read_req_valid),
		.read_req_ready  (read_req_ready),
		.read_resp       (read_resp),
		.read_resp_valid (read_resp_valid),
		.vertex          (vertex),
		.vertex_valid    (vertex_valid),
		.vertex_ready    (vertex_ready)
	);

	vertex_checker check (
		.clock            (clock),
		.rstn             (rstn),
		.job              (job),
		.job_valid        (job_valid),
		.job_ready        (job_ready),
		.read_req         (read_req),
		.read_req_valid   (read_req_valid),
		.read_req_ready   (read_req_ready),
		.vertex           (vertex),
		.vertex_valid     (vertex_valid),
		.vertex_ready     (vertex_ready),
		.error_count      (check_errors),
		.pending          (pending),
		.vertices_checked (vertices_checked),
		.requests_checked (requests_checked)
	);

	initial begin
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////////////////////
	function automatic read_resp_t make_response(input read_req_t r);
		read_resp_t  resp;
		logic [31:0] word_index;
		logic [31:0] value;
		resp.array = r.array;
		resp.count = r.count;
		for (int k = 0; k < `VERTICES_PER_LINE; k++) begin
			word_index = (r.address >> 2) + k; // byte address / 4
			case (r.array)
				in_degree:  value = word_index % 7;
				out_degree: value = word_index % 5;
				default:    value = word_index;
			endcase
			resp.data[k*`VERTEX_BITS +: `VERTEX_BITS] = vertex_word_t'(value);
		end
		return resp;
	endfunction

	always @(posedge clock) begin
		read_resp_valid <= 1'b0;
		if (read_req_valid && read_req_ready) begin
			accepted_q.push_back(read_req);
			if (accepted_q.size() == 3) begin
				// answer the batch in random order
				while (accepted_q.size() != 0) begin
					pick = $urandom_range(accepted_q.size() - 1);
					resp_q.push_back(make_response(accepted_q[pick]));
					accepted_q.delete(pick);
				end
				delay = $urandom_range(max_delay);
			end
		end else if (resp_q.size() != 0) begin
			if (delay > 0) begin
				delay--;
			end else begin
				read_resp       <= resp_q.pop_front();
				read_resp_valid <= 1'b1;
				delay = $urandom_range(max_delay);
			end
		end
	end

	always @(posedge clock) begin
		vertex_ready   <= ($urandom_range(99) < ready_pct);
		read_req_ready <= (ready_pct >= 100) || ($urandom_range(1) == 1);
	end

	////////////////////////////////////////////////////////////////////////////
	// one job from the table
	////////////////////////////////////////////////////////////////////////////
	task automatic run_test(input int row);
		test_row_t t;
		int        cycles;
		int        errors_before;
		int        vertices_before;
		int        kept;
		t = tests[row];
		errors_before = check_errors + tb_errors;
		vertices_before = vertices_checked;
		@(posedge clock);
		ready_pct <= t.ready_pct;
		max_delay <= t.max_delay;
		job       <= '{t.num_vertices, t.in_base, t.out_base, t.edges_base};
		job_valid <= 1'b1;
		cycles = 0;
		@(posedge clock);
		while (!job_ready) begin
			cycles++;
			if (cycles > 200) begin
				$display("test %0d: timed out waiting for job_ready", row);
				timed_out = 1'b1;
				return;
			end
			@(posedge clock);
		end
		job_valid <= 1'b0; // accepted on this edge
		cycles = 0;
		@(negedge clock);
		while (!(job_ready && pending == 0 && !vertex_valid)) begin
			cycles++;
			if (cycles > 5000) begin
				$display("test %0d: timed out waiting for requests and vertices", row);
				timed_out = 1'b1;
				return;
			end
			@(negedge clock);
		end
		kept = vertices_checked - vertices_before;
		if (kept != int'(t.kept)) begin
			$display("test %0d: expected %0d vertices at the output, received %0d",
				row, t.kept, kept);
			tb_errors++;
		end
		$display("test %0d: %0d vertices in, %0d out, %s", row, t.num_vertices, kept,
			(check_errors + tb_errors == errors_before) ? "ok" : "FAILED");
	endtask

	initial begin
		void'($urandom(89193));
		// vertices, in base, out base, edges base, ready %, max delay, kept
		tests[0] = '{16'd4,  32'h0000, 32'h0a00, 32'h3000, 100, 0, 16'd3};
		tests[1] = '{16'd10, 32'h0000, 32'h0a00, 32'h3000, 100, 3, 16'd9};
		tests[2] = '{16'd10, 32'h0000, 32'h0a00, 32'h3000, 30,  6, 16'd9};
		tests[3] = '{16'd0,  32'h1000, 32'h2000, 32'h4000, 100, 0, 16'd0};
		tests[4] = '{16'd6,  32'h1000, 32'h2000, 32'h4000, 100, 2, 16'd6};
		tests[5] = '{16'd37, 32'h1000, 32'h2000, 32'h5000, 60,  4, 16'd36};
		tests[6] = '{16'd40, 32'h0000, 32'h0a00, 32'h6000, 50,  5, 16'd38};
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		for (int row = 0; row < num_tests; row++) begin
			if (!timed_out)
				run_test(row);
		end
		$display("tests %0d, requests checked %0d, vertices checked %0d, errors %0d",
			num_tests, requests_checked, vertices_checked, check_errors + tb_errors);
		if (check_errors + tb_errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/vertex_pkg.sv
source/vertex_request_gen.sv
source/cacheline_gather.sv
source/vertex_unpack.sv
source/vertex_job_queue.sv
source/vertex_job_control.sv
testbench/vertex_checker.sv
testbench/tb_vertex_job_control.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module tb_vertex_job_control -f sim.f -o vsim

run: compile
	./obj_dir/vsim | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
